//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := dcache_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/dcache_checker.sv
// dcache_checker: concurrent assertions on the load cache handshakes
// bound into dcache_top
`default_nettype none

module dcache_checker
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  req_ready,
    input  logic  resp_valid,
    input  logic  resp_ready,
    input  word_t resp_data,
    input  logic  resp_hit
);

    int fail_cnt = 0;   // read by the testbench at the end

    // a stalled response keeps its valid and payload
    a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_hit))
    else
    begin
        $error("resp_valid or its payload changed while resp_ready was low");
        fail_cnt++;
    end

    // first cycle out of reset
    a_ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> req_ready)
    else
    begin
        $error("req_ready low in the cycle after reset");
        fail_cnt++;
    end

    a_no_resp_in_reset: assert property (@(posedge clk) !arst_n |-> !resp_valid)
    else
    begin
        $error("resp_valid high during reset");
        fail_cnt++;
    end

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
// dcache_tb: testbench for the load cache
// preloads memory, runs a table of loads and checks every response
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;

    localparam int NUM_SETS      = 16;
    localparam int BLOCK_WORDS   = 4;
    localparam int MEM_LATENCY   = 3;
    localparam int PRELOAD_WORDS = 1024;   // covers every address in the table
    localparam int TIMEOUT       = 200;
    localparam int NUM_TESTS     = 25;

    localparam logic [1:0] K_SEQ = 2'd0;   // one load, wait for its answer
    localparam logic [1:0] K_LAT = 2'd1;   // same, plus hit latency check
    localparam logic [1:0] K_STR = 2'd2;   // streamed under back-pressure
    localparam logic [1:0] K_RST = 2'd3;   // reset pulse first

    typedef struct packed {
        logic [95:0] name;
        addr_t       addr;
        logic        hit;
        logic [1:0]  kind;
    } entry_t;

    // 16 sets of 4 words: set = addr[7:4], tag = addr[15:8]
    entry_t tbl [NUM_TESTS] = '{
        '{"cold_blk4",    16'h0040, 1'b0, K_SEQ},
        '{"hit_w1",       16'h0044, 1'b1, K_LAT},
        '{"hit_w3",       16'h004c, 1'b1, K_LAT},
        '{"hit_repeat",   16'h0044, 1'b1, K_LAT},
        '{"cold_set2",    16'h0128, 1'b0, K_SEQ},
        '{"hit_set2",     16'h0120, 1'b1, K_LAT},
        '{"repl_a",       16'h0050, 1'b0, K_SEQ},   // set 5, way 0
        '{"repl_b",       16'h0154, 1'b0, K_SEQ},   // way 1
        '{"repl_a_hit",   16'h0058, 1'b1, K_SEQ},   // b becomes lru
        '{"repl_c",       16'h025c, 1'b0, K_SEQ},   // evicts b
        '{"repl_a_keep",  16'h0050, 1'b1, K_SEQ},
        '{"repl_b_gone",  16'h0150, 1'b0, K_SEQ},
        '{"bp_miss9",     16'h0090, 1'b0, K_STR},
        '{"bp_hit9",      16'h0094, 1'b1, K_STR},
        '{"bp_miss1",     16'h0310, 1'b0, K_STR},
        '{"bp_hit9b",     16'h0098, 1'b1, K_STR},
        '{"bp_hit1",      16'h031c, 1'b1, K_STR},
        '{"bp_miss9_t1",  16'h0190, 1'b0, K_STR},   // second way of set 9
        '{"bp_hit9_t0",   16'h009c, 1'b1, K_STR},
        '{"bp_miss9_t2",  16'h0290, 1'b0, K_STR},   // evicts tag 1
        '{"bp_miss9_t1b", 16'h0194, 1'b0, K_STR},   // evicts tag 0
        '{"bp_hit9_t2",   16'h0298, 1'b1, K_STR},
        '{"bp_hit4",      16'h0044, 1'b1, K_STR},
        '{"rst_miss",     16'h0044, 1'b0, K_RST},
        '{"rst_hit",      16'h0048, 1'b1, K_LAT}
    };

    logic                       clk        = 1'b0;
    logic                       arst_n     = 1'b0;
    logic                       req_valid  = 1'b0;
    addr_t                      req_addr   = '0;
    logic                       resp_ready = 1'b1;
    logic                       pl_en      = 1'b0;
    logic [WORD_ADDR_WIDTH-1:0] pl_addr    = '0;
    word_t                      pl_data    = '0;
    logic                       req_ready;
    logic                       resp_valid;
    word_t                      resp_data;
    logic                       resp_hit;

    word_t       mem_copy [PRELOAD_WORDS];
    logic [31:0] rng_state  = 32'd61107;
    int          cyc        = 0;
    int          idx_q [$];      // loads in flight, oldest first
    int          cyc_q [$];
    logic        bp_on      = 1'b0;
    logic        hold_resp  = 1'b0;
    logic        seen_stall = 1'b0;

    dcache_top #(
        .NUM_SETS(NUM_SETS), .BLOCK_WORDS(BLOCK_WORDS), .MEM_LATENCY(MEM_LATENCY)
    ) u_dut (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .resp_valid(resp_valid), .resp_ready(resp_ready),
        .resp_data(resp_data), .resp_hit(resp_hit),
        .pl_en(pl_en), .pl_addr(pl_addr), .pl_data(pl_data)
    );

    bind dcache_top dcache_checker u_chk (
        .clk(clk), .arst_n(arst_n), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_ready(resp_ready),
        .resp_data(resp_data), .resp_hit(resp_hit)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    function automatic word_t lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // random stalls only while a stream is running
    always @(negedge clk)
    begin : bp_drive
        word_t r;
        if (hold_resp)
            resp_ready = 1'b0;   // response parked ahead of a reset
        else if (bp_on)
        begin
            r = lcg_next();
            resp_ready = r[16];
        end
        else
            resp_ready = 1'b1;
    end

    always @(posedge clk)
    begin : resp_monitor
        int    idx;
        string nm;
        if (resp_valid && resp_ready)
        begin
            if (idx_q.size() == 0)
                abort_run("a response arrived with no load outstanding");
            idx = idx_q.pop_front();
            nm  = $sformatf("%0s", tbl[idx].name);
            check_value(nm, mem_copy[tbl[idx].addr >> BYTE_OFFSET_BITS], resp_data);
            check_value({nm, " hit"}, 32'(tbl[idx].hit), 32'(resp_hit));
            if (tbl[idx].kind == K_LAT)
                check_value({nm, " latency"}, 32'd2, cyc - cyc_q[0]);
            void'(cyc_q.pop_front());
        end
        if (bp_on && resp_valid && !resp_ready && !req_ready)
            seen_stall = 1'b1;
    end

    task automatic reset_dut();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (8) @(negedge clk);
        check_value("reset_resp_valid", 32'd0, 32'(resp_valid));
        arst_n = 1'b1;
    endtask

    // a hit on a cached address, left waiting in the response register
    task automatic park_response(input int idx);
        int    n;
        string nm;
        nm        = $sformatf("%0s parked", tbl[idx].name);
        hold_resp = 1'b1;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = tbl[idx].addr;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end while (!resp_valid && n < TIMEOUT);
        if (!resp_valid)
            abort_run("no response showed up while resp_ready was held low");
        check_value(nm, mem_copy[tbl[idx].addr >> BYTE_OFFSET_BITS], resp_data);
        check_value({nm, " hit"}, 32'd1, 32'(resp_hit));
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic preload();
        for (int i = 0; i < PRELOAD_WORDS; i++)
        begin
            @(negedge clk);
            pl_en       = 1'b1;
            pl_addr     = WORD_ADDR_WIDTH'(i);
            pl_data     = lcg_next();
            mem_copy[i] = pl_data;
        end
        @(negedge clk);
        pl_en = 1'b0;
    endtask

    // hold the request until the DUT takes it
    task automatic issue(input int idx);
        int   n;
        logic taken;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = tbl[idx].addr;
        n = 0;
        do
        begin
            @(posedge clk);
            taken = req_ready;
            n++;
        end while (!taken && n < TIMEOUT);
        if (!taken)
            abort_run("request was not accepted before the timeout");
        idx_q.push_back(idx);
        cyc_q.push_back(cyc);
    endtask

    // wait until every load has its response, ends just after a rising edge
    task automatic drain();
        int n;
        @(negedge clk);
        req_valid = 1'b0;
        n = 0;
        while (idx_q.size() != 0 && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (idx_q.size() != 0)
            abort_run("responses still outstanding after the timeout");
        @(posedge clk);
        if (bp_on)
        begin
            bp_on = 1'b0;
            if (!seen_stall)
                abort_run("req_ready never fell while the response stage was held");
        end
    endtask

    initial
    begin
        reset_dut();
        preload();
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            if (tbl[i].kind != K_STR)
                drain();
            else if (!bp_on)
            begin
                drain();
                bp_on = 1'b1;
            end
            if (tbl[i].kind == K_RST)
            begin
                park_response(i);   // reset has a live response to clear
                reset_dut();
                hold_resp = 1'b0;
            end
            issue(i);
        end
        drain();
        repeat (10) @(negedge clk);   // a duplicate response would show up here
        if (u_dut.u_chk.fail_cnt == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            $display("Simulation FAILED");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- list.f
source/dcache_pkg.sv
source/pipe_reg.sv
source/dcache_array.sv
source/refill_ctrl.sv
source/backing_mem.sv
source/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

//--- source/backing_mem.sv
// backing_mem: word-addressed main memory behind the cache
// fixed read latency through a shift register, plus a preload write port
`default_nettype none

module backing_mem
    import dcache_pkg::*;
#(
    parameter int MEM_WORDS   = 4096,
    parameter int MEM_LATENCY = DEF_MEM_LATENCY
)(
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic                       pl_en,      // one preload write per cycle
    input  logic [WORD_ADDR_WIDTH-1:0] pl_addr,
    input  word_t                      pl_data,

    input  logic                       mem_req,
    input  logic [WORD_ADDR_WIDTH-1:0] mem_addr,
    output logic                       mem_rvalid,
    output word_t                      mem_rdata
);

    localparam int IDX_BITS = $clog2(MEM_WORDS);

    word_t                  mem [MEM_WORDS];
    logic [MEM_LATENCY-1:0] vld_sr;
    word_t                  dat_sr [MEM_LATENCY];
    logic [IDX_BITS-1:0]    pl_idx;
    logic [IDX_BITS-1:0]    rd_idx;

    // upper word address bits alias onto the array
    assign pl_idx = pl_addr[IDX_BITS-1:0];
    assign rd_idx = mem_addr[IDX_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (pl_en)
            mem[pl_idx] <= pl_data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vld_sr <= '0;
        end
        else
        begin
            vld_sr[0] <= mem_req;
            for (int i = 1; i < MEM_LATENCY; i++)
                vld_sr[i] <= vld_sr[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_req)
            dat_sr[0] <= mem[rd_idx];
        for (int i = 1; i < MEM_LATENCY; i++)
            dat_sr[i] <= dat_sr[i-1];   // several reads in flight
    end

    assign mem_rvalid = vld_sr[MEM_LATENCY-1];
    assign mem_rdata  = dat_sr[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- source/dcache_array.sv
// dcache_array: 2-way set-associative tag, valid, LRU and data store
// lookup is combinational on addr, a fill replaces one whole block
`default_nettype none

module dcache_array
    import dcache_pkg::*;
#(
    parameter int NUM_SETS    = DEF_NUM_SETS,
    parameter int BLOCK_WORDS = DEF_BLOCK_WORDS
)(
    input  logic                    clk,
    input  logic                    arst_n,

    input  addr_t                   addr,
    output logic                    hit,
    output word_t                   rd_data,

    input  logic                    touch_en,     // hit consumed, refresh LRU
    input  logic                    fill_en,
    input  word_t [BLOCK_WORDS-1:0] fill_block,
    output logic                    victim_way
);

    localparam int NUM_WAYS = 2;
    localparam int OFF_BITS = $clog2(BLOCK_WORDS);
    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = ADDR_WIDTH - BYTE_OFFSET_BITS - OFF_BITS - SET_BITS;

    typedef word_t [BLOCK_WORDS-1:0] block_t;

    logic [OFF_BITS-1:0] word_off;
    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] tag;

    block_t              blocks [NUM_WAYS][NUM_SETS];
    logic [TAG_BITS-1:0] tags   [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] valids [NUM_SETS];
    logic [NUM_SETS-1:0] lru;        // way that was not used last, per set

    logic [NUM_WAYS-1:0] way_hit;
    logic                hit_way;

    // tag | set | word in block | byte offset
    assign word_off = addr[BYTE_OFFSET_BITS +: OFF_BITS];
    assign set_idx  = addr[BYTE_OFFSET_BITS + OFF_BITS +: SET_BITS];
    assign tag      = addr[ADDR_WIDTH-1 -: TAG_BITS];

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_hit[w] = valids[set_idx][w] && (tags[w][set_idx] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];                         // both ways never match
    assign rd_data = blocks[hit_way][set_idx][word_off];

    // empty way first, else the LRU one
    assign victim_way = !valids[set_idx][0] ? 1'b0 :
                        !valids[set_idx][1] ? 1'b1 : lru[set_idx];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valids <= '{default: '0};
            lru    <= '0;
        end
        else if (fill_en)
        begin
            valids[set_idx][victim_way] <= 1'b1;
            lru[set_idx]                <= ~victim_way;   // new block is most recent
        end
        else if (touch_en)
        begin
            lru[set_idx] <= ~hit_way;
        end
    end

    // block data and tag, written only by a fill
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            blocks[victim_way][set_idx] <= fill_block;
            tags[victim_way][set_idx]   <= tag;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_pkg.sv
// dcache_pkg: word and address widths, address layout constants
// and default geometry for the load cache
`default_nettype none

package dcache_pkg;

    localparam int DATA_WIDTH       = 32;
    localparam int ADDR_WIDTH       = 16;   // byte address
    localparam int WORD_BYTES       = 4;
    localparam int BYTE_OFFSET_BITS = $clog2(WORD_BYTES);
    localparam int WORD_ADDR_WIDTH  = ADDR_WIDTH - BYTE_OFFSET_BITS;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // load response as it leaves the cache
    typedef struct packed {
        word_t data;
        logic  hit;    // low when the word came through a refill
    } resp_t;

    // default geometry, overridden from dcache_top
    localparam int DEF_NUM_SETS    = 16;
    localparam int DEF_BLOCK_WORDS = 4;
    localparam int DEF_MEM_LATENCY = 3;

endpackage

`default_nettype wire

//--- source/dcache_top.sv
// dcache_top: load path around a 2-way data cache
// request register, lookup and refill, backing memory, response register
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS    = DEF_NUM_SETS,
    parameter int BLOCK_WORDS = DEF_BLOCK_WORDS,
    parameter int MEM_LATENCY = DEF_MEM_LATENCY
)(
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic                       req_valid,
    output logic                       req_ready,
    input  addr_t                      req_addr,

    output logic                       resp_valid,
    input  logic                       resp_ready,
    output word_t                      resp_data,
    output logic                       resp_hit,

    input  logic                       pl_en,
    input  logic [WORD_ADDR_WIDTH-1:0] pl_addr,   // word address
    input  word_t                      pl_data
);

    logic                       lk_valid;
    logic                       lk_ready;
    addr_t                      lk_addr;
    logic                       arr_hit;
    word_t                      arr_data;
    logic                       touch_en;
    logic                       fill_en;
    word_t [BLOCK_WORDS-1:0]    fill_block;
    logic                       mem_req;
    logic [WORD_ADDR_WIDTH-1:0] mem_addr;
    logic                       mem_rvalid;
    word_t                      mem_rdata;
    logic                       rs_valid;
    logic                       rs_ready;
    word_t                      rs_data;
    logic                       rs_hit;
    resp_t                      rs_pkt;
    resp_t                      resp_q;

    assign rs_pkt    = '{data: rs_data, hit: rs_hit};
    assign resp_data = resp_q.data;
    assign resp_hit  = resp_q.hit;

    pipe_reg #(.payload_t(addr_t)) u_req (
        .clk(clk), .arst_n(arst_n),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req_addr),
        .out_valid(lk_valid), .out_ready(lk_ready), .out_data(lk_addr)
    );

    refill_ctrl #(.BLOCK_WORDS(BLOCK_WORDS)) u_ctrl (
        .clk(clk), .arst_n(arst_n),
        .lk_valid(lk_valid), .lk_ready(lk_ready), .lk_addr(lk_addr),
        .arr_hit(arr_hit), .arr_data(arr_data), .touch_en(touch_en),
        .fill_en(fill_en), .fill_block(fill_block),
        .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .rs_valid(rs_valid), .rs_ready(rs_ready), .rs_data(rs_data), .rs_hit(rs_hit)
    );

    // looked up with the address held in the request register
    dcache_array #(.NUM_SETS(NUM_SETS), .BLOCK_WORDS(BLOCK_WORDS)) u_array (
        .clk(clk), .arst_n(arst_n),
        .addr(lk_addr), .hit(arr_hit), .rd_data(arr_data),
        .touch_en(touch_en), .fill_en(fill_en), .fill_block(fill_block),
        .victim_way()   // replacement choice is used inside the array
    );

    backing_mem #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
        .clk(clk), .arst_n(arst_n),
        .pl_en(pl_en), .pl_addr(pl_addr), .pl_data(pl_data),
        .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
    );

    pipe_reg #(.payload_t(resp_t)) u_resp (
        .clk(clk), .arst_n(arst_n),
        .in_valid(rs_valid), .in_ready(rs_ready), .in_data(rs_pkt),
        .out_valid(resp_valid), .out_ready(resp_ready), .out_data(resp_q)
    );

endmodule

`default_nettype wire

//--- source/pipe_reg.sv
// pipe_reg: one-entry valid/ready register stage
// carries any packed payload, holds it until the consumer takes it
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic take;   // transfer on the input side

    // room when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;   // refill or drain
        end
    end

    // payload moves only on a transfer
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- source/refill_ctrl.sv
// refill_ctrl: lookup stage control for the load cache
// answers hits directly, on a miss reads a block word by word and fills the array
`default_nettype none

module refill_ctrl
    import dcache_pkg::*;
#(
    parameter int BLOCK_WORDS = DEF_BLOCK_WORDS
)(
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic                       lk_valid,
    output logic                       lk_ready,
    input  addr_t                      lk_addr,

    input  logic                       arr_hit,
    input  word_t                      arr_data,
    output logic                       touch_en,
    output logic                       fill_en,
    output word_t [BLOCK_WORDS-1:0]    fill_block,

    output logic                       mem_req,
    output logic [WORD_ADDR_WIDTH-1:0] mem_addr,
    input  logic                       mem_rvalid,
    input  word_t                      mem_rdata,

    output logic                       rs_valid,
    input  logic                       rs_ready,
    output word_t                      rs_data,
    output logic                       rs_hit
);

    localparam int OFF_BITS = $clog2(BLOCK_WORDS);
    localparam logic [OFF_BITS-1:0] LAST_WORD = OFF_BITS'(BLOCK_WORDS - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,   // issuing reads
        ST_WAIT,    // draining read returns
        ST_FILL,
        ST_RESP
    } state_t;

    state_t                              state;
    state_t                              state_nxt;
    logic [OFF_BITS-1:0]                 issue_cnt;
    logic [OFF_BITS-1:0]                 recv_cnt;
    logic [OFF_BITS-1:0]                 word_off;
    logic [WORD_ADDR_WIDTH-OFF_BITS-1:0] block_base;
    word_t [BLOCK_WORDS-1:0]             blk_buf;

    assign word_off   = lk_addr[BYTE_OFFSET_BITS +: OFF_BITS];
    assign block_base = lk_addr[ADDR_WIDTH-1 : BYTE_OFFSET_BITS + OFF_BITS];

    assign mem_req    = (state == ST_FETCH);
    assign mem_addr   = {block_base, issue_cnt};   // block aligned, word by word
    assign fill_en    = (state == ST_FILL);
    assign fill_block = blk_buf;

    // hit answered straight from the array, miss answered from the buffer
    assign rs_hit   = (state == ST_IDLE);
    assign rs_valid = (state == ST_RESP) || (rs_hit && lk_valid && arr_hit);
    assign rs_data  = rs_hit ? arr_data : blk_buf[word_off];
    assign lk_ready = rs_ready && ((rs_hit && arr_hit) || (state == ST_RESP));
    assign touch_en = rs_hit && lk_valid && arr_hit && rs_ready;

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
                if (lk_valid && !arr_hit)
                    state_nxt = ST_FETCH;
            ST_FETCH:
                if (issue_cnt == LAST_WORD)
                    state_nxt = ST_WAIT;
            ST_WAIT:
                if (mem_rvalid && (recv_cnt == LAST_WORD))
                    state_nxt = ST_FILL;
            ST_FILL:
                state_nxt = ST_RESP;
            ST_RESP:
                if (rs_ready)
                    state_nxt = ST_IDLE;   // lookup consumed with the response
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= ST_IDLE;
            issue_cnt <= '0;
            recv_cnt  <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (mem_req)
                issue_cnt <= issue_cnt + 1'b1;   // wraps back to 0 after a block
            if (mem_rvalid)
                recv_cnt <= recv_cnt + 1'b1;
        end
    end

    // returned words land in order
    always_ff @(posedge clk)
    begin
        if (mem_rvalid)
            blk_buf[recv_cnt] <= mem_rdata;
    end

endmodule

`default_nettype wire
